/* flist.f */
conv_acc_pkg.sv
sp_ram.sv
buffer_bank.sv
max_pool.sv
pool_top.sv
tb_pool_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pool_top \
	-f flist.f -o sim_pool_top > build.log 2>&1 &&
./obj_dir/sim_pool_top > sim.log 2>&1 ||
echo "build or simulation returned an error"
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "no pass result in sim.log"; exit 1; }
echo "simulation passed"
exit 0

/* tb_pool_top.sv */
module tb_pool_top;

	timeunit 1ns;
	timeprecision 1ps;

	// 4x4 map, row-major; windows cover mixed, all 0x80, all negative, 0x7f
	localparam logic [127:0] hand_pixels = 128'h05fd8080_12f08080_ff817f80_c0fe9081;
	localparam logic [31:0]  hand_max    = 32'h12_80_ff_7f;

	// engine cycles per test: 4 + (k*k+2) * outputs, then host traffic at 3 cycles an access
	localparam int pool_cycles    = (4 + 6 * 4) + (4 + 6 * 48) + (4 + 18 * 8) + 4;
	localparam int host_accesses  = (4 * 3 + 16 + 192 + 128 + 4) + (4 + 48 + 8 + 4);
	localparam int timeout_cycles = pool_cycles + 3 * host_accesses + 400;

	logic                    clk;
	logic                    rst;
	logic                    start;
	conv_acc_pkg::ram_req_t  host_req;
	conv_acc_pkg::bank_sel_t host_bank;
	logic [7:0]              host_rdata;
	logic                    finish;
	logic                    busy;

	logic [7:0] img [4096];
	logic [7:0] exp_out [1024];
	int         seed = 79;
	int         cycle_cnt = 0;
	int         run_cnt = 0;
	int         finish_cnt = 0;

	pool_top #(
		.ADDR_W      (12),
		.PARAM_ADDR_W(2)
	) u_pool_top (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.host_req  (host_req),
		.host_bank (host_bank),
		.host_rdata(host_rdata),
		.finish    (finish),
		.busy      (busy)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_cycles) begin
			$display("timeout: the tests did not complete within %0d cycles", timeout_cycles);
			$display("RESULT: FAIL");
			$fatal(1, "simulation timed out");
		end
	end

	always @(negedge clk) begin
		if (finish === 1'b1) begin
			finish_cnt <= finish_cnt + 1;
		end
	end

	task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic write_word(input conv_acc_pkg::bank_sel_t bank, input int addr,
		input logic [7:0] data);
		conv_acc_pkg::ram_req_t req;
		req       = '0;
		req.cs    = 1'b1;
		req.we    = 1'b1;
		req.addr  = 16'(addr);
		req.wdata = data;
		@(posedge clk);
		host_req  <= req;
		host_bank <= bank;
		@(posedge clk);
		host_req  <= '0;
	endtask

	// data shows up one cycle after the request
	task automatic read_word(input conv_acc_pkg::bank_sel_t bank, input int addr,
		output logic [7:0] data);
		conv_acc_pkg::ram_req_t req;
		req      = '0;
		req.cs   = 1'b1;
		req.addr = 16'(addr);
		@(posedge clk);
		host_req  <= req;
		host_bank <= bank;
		@(posedge clk);
		host_req  <= '0;
		@(negedge clk);
		data = host_rdata;
	endtask

	task automatic run_pool();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		run_cnt++;
		@(negedge clk);
		while (finish !== 1'b1) @(negedge clk);
		@(negedge clk);
		check_value("finish", 16'(finish), 16'd0);
		check_value("busy", 16'(busy), 16'd0);
	endtask

	task automatic load_layer(input int rows, input int chans, input int k);
		write_word(conv_acc_pkg::bank_param, int'(conv_acc_pkg::param_addr_rows), 8'(rows));
		write_word(conv_acc_pkg::bank_param, int'(conv_acc_pkg::param_addr_channels), 8'(chans));
		write_word(conv_acc_pkg::bank_param, int'(conv_acc_pkg::param_addr_kernel), 8'(k));
	endtask

	task automatic fill_random(input int count);
		for (int i = 0; i < count; i++) begin
			img[i] = 8'($random(seed));
			write_word(conv_acc_pkg::bank_input, i, img[i]);
		end
	endtask

	// signed max of every window, outputs in channel, row, column order
	task automatic pool_model(input int rows, input int chans, input int k);
		int                n;
		int                idx;
		logic signed [7:0] best;
		logic signed [7:0] px;
		n   = rows / k;
		idx = 0;
		for (int c = 0; c < chans; c++) begin
			for (int wr = 0; wr < n; wr++) begin
				for (int wc = 0; wc < n; wc++) begin
					best = -8'sd128;
					for (int ro = 0; ro < k; ro++) begin
						for (int co = 0; co < k; co++) begin
							px = img[c * rows * rows + (wr * k + ro) * rows + wc * k + co];
							if (px > best) best = px;
						end
					end
					exp_out[idx] = best;
					idx++;
				end
			end
		end
	endtask

	task automatic test_hand_signed();
		logic [7:0] got;
		load_layer(4, 1, 2);
		for (int i = 0; i < 16; i++) begin
			write_word(conv_acc_pkg::bank_input, i, hand_pixels[127 - 8 * i -: 8]);
		end
		run_pool();
		for (int i = 0; i < 4; i++) begin
			read_word(conv_acc_pkg::bank_output, i, got);
			check_value("host_rdata", 16'(got), 16'(hand_max[31 - 8 * i -: 8]));
		end
	endtask

	task automatic test_random(input int rows, input int chans, input int k);
		logic [7:0] got;
		int         count;
		count = chans * (rows / k) * (rows / k);
		load_layer(rows, chans, k);
		fill_random(rows * rows * chans);
		run_pool();
		pool_model(rows, chans, k);
		for (int i = 0; i < count; i++) begin
			read_word(conv_acc_pkg::bank_output, i, got);
			check_value("host_rdata", 16'(got), 16'(exp_out[i]));
		end
	endtask

	// kernel 3 is rejected, seeded outputs must survive
	task automatic test_bad_kernel();
		logic [7:0] got;
		for (int i = 0; i < 4; i++) begin
			write_word(conv_acc_pkg::bank_output, i, 8'ha0 + 8'(i));
		end
		load_layer(4, 1, 3);
		run_pool();
		for (int i = 0; i < 4; i++) begin
			read_word(conv_acc_pkg::bank_output, i, got);
			check_value("host_rdata", 16'(got), 16'(8'ha0 + 8'(i)));
		end
	endtask

	initial begin
		rst       = 1'b0;
		start     = 1'b0;
		host_req  = '0;
		host_bank = conv_acc_pkg::bank_param;
		repeat (8) @(posedge clk);
		rst <= 1'b1;
		test_hand_signed();
		test_random(8, 3, 2);
		test_random(8, 2, 4);
		test_bad_kernel();
		check_value("finish_cnt", 16'(finish_cnt), 16'(run_cnt));
		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* pool_top.sv */
module pool_top #(
	parameter int ADDR_W       = 12,
	parameter int PARAM_ADDR_W = 2
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,
	input  conv_acc_pkg::ram_req_t  host_req,
	input  conv_acc_pkg::bank_sel_t host_bank,
	output logic [7:0]              host_rdata,
	output logic                    finish,
	output logic                    busy
);

	conv_acc_pkg::ram_req_t param_req;
	conv_acc_pkg::ram_req_t input_req;
	conv_acc_pkg::ram_req_t output_req;

	logic [7:0] param_rdata;
	logic [7:0] input_rdata;
	logic [7:0] output_rdata;

	logic hit_param;
	logic hit_input;
	logic hit_output;

	// bank of the read issued last cycle
	conv_acc_pkg::bank_sel_t host_bank_q;

	assign hit_param  = (host_bank == conv_acc_pkg::bank_param);
	assign hit_input  = (host_bank == conv_acc_pkg::bank_input);
	assign hit_output = (host_bank == conv_acc_pkg::bank_output);

	max_pool #(
		.ADDR_W      (ADDR_W),
		.PARAM_ADDR_W(PARAM_ADDR_W)
	) u_max_pool (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.finish     (finish),
		.busy       (busy),
		.param_req  (param_req),
		.input_req  (input_req),
		.output_req (output_req),
		.param_rdata(param_rdata),
		.input_rdata(input_rdata)
	);

	buffer_bank #(.ADDR_W(PARAM_ADDR_W)) u_param_bank (
		.clk     (clk),
		.rst     (rst),
		.busy    (busy),
		.host_hit(hit_param),
		.host_req(host_req),
		.eng_req (param_req),
		.rdata   (param_rdata)
	);

	buffer_bank #(.ADDR_W(ADDR_W)) u_input_bank (
		.clk     (clk),
		.rst     (rst),
		.busy    (busy),
		.host_hit(hit_input),
		.host_req(host_req),
		.eng_req (input_req),
		.rdata   (input_rdata)
	);

	// engine only writes here, read data goes to the host
	buffer_bank #(.ADDR_W(ADDR_W)) u_output_bank (
		.clk     (clk),
		.rst     (rst),
		.busy    (busy),
		.host_hit(hit_output),
		.host_req(host_req),
		.eng_req (output_req),
		.rdata   (output_rdata)
	);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			host_bank_q <= conv_acc_pkg::bank_param;
		end else begin
			host_bank_q <= host_bank;
		end
	end

	always_comb begin
		case (host_bank_q)
			conv_acc_pkg::bank_param:  host_rdata = param_rdata;
			conv_acc_pkg::bank_input:  host_rdata = input_rdata;
			conv_acc_pkg::bank_output: host_rdata = output_rdata;
			default:                   host_rdata = 8'h00;
		endcase
	end

endmodule

/* max_pool.sv */
module max_pool #(
	parameter int ADDR_W       = 12,
	parameter int PARAM_ADDR_W = 2
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	output logic                   finish,
	output logic                   busy,
	output conv_acc_pkg::ram_req_t param_req,
	output conv_acc_pkg::ram_req_t input_req,
	output conv_acc_pkg::ram_req_t output_req,
	input  logic [7:0]             param_rdata,
	input  logic [7:0]             input_rdata
);

	conv_acc_pkg::pool_state_t state;
	conv_acc_pkg::pool_state_t next_state;

	// layer parameters
	logic [7:0] rows;
	logic [7:0] channels;
	logic       k_is4;

	logic [1:0]              load_cnt;
	logic [PARAM_ADDR_W-1:0] param_addr;

	// window walk
	logic [1:0]        col_off;
	logic [1:0]        row_off;
	logic [7:0]        win_col;
	logic [7:0]        win_row;
	logic [7:0]        chan;
	logic              rd_done;
	logic [ADDR_W-1:0] out_addr;

	// fold pipeline, one cycle behind the reads
	logic              rd_valid;
	logic              rd_first;
	logic signed [7:0] pixel;
	logic signed [7:0] fold_base;
	logic signed [7:0] run_max;

	logic [1:0] k_shift;
	logic [1:0] k_last;
	logic [7:0] win_last;
	logic       reading;
	logic       elem_last;
	logic       win_final;
	logic       kernel_ok;

	logic [ADDR_W-1:0] rows_w;
	logic [ADDR_W-1:0] row_idx;
	logic [ADDR_W-1:0] col_idx;
	logic [ADDR_W-1:0] rd_addr;

	assign k_shift   = k_is4 ? 2'd2 : 2'd1;
	assign k_last    = k_is4 ? 2'd3 : 2'd1;
	assign win_last  = (rows >> k_shift) - 8'd1;
	assign reading   = (state == conv_acc_pkg::st_load_window) && !rd_done;
	assign elem_last = (col_off == k_last) && (row_off == k_last);
	assign win_final = (win_col == win_last) && (win_row == win_last)
		&& (chan == channels - 8'd1);
	assign kernel_ok = (param_rdata == 8'd2) || (param_rdata == 8'd4);

	assign rows_w  = ADDR_W'(rows);
	assign row_idx = (ADDR_W'(win_row) << k_shift) + ADDR_W'(row_off);
	assign col_idx = (ADDR_W'(win_col) << k_shift) + ADDR_W'(col_off);
	// channel-major: plane, then row, then column
	assign rd_addr = ADDR_W'(chan) * rows_w * rows_w + row_idx * rows_w + col_idx;

	always_comb begin
		case (load_cnt)
			2'd0:    param_addr = PARAM_ADDR_W'(conv_acc_pkg::param_addr_rows);
			2'd1:    param_addr = PARAM_ADDR_W'(conv_acc_pkg::param_addr_channels);
			default: param_addr = PARAM_ADDR_W'(conv_acc_pkg::param_addr_kernel);
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= conv_acc_pkg::st_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			conv_acc_pkg::st_idle: begin
				if (start) begin
					next_state = conv_acc_pkg::st_load_param;
				end
			end
			conv_acc_pkg::st_load_param: begin
				// kernel arrives in the last load cycle
				if (load_cnt == 2'd3) begin
					if (kernel_ok && (rows != 8'd0) && (channels != 8'd0)) begin
						next_state = conv_acc_pkg::st_load_window;
					end else begin
						next_state = conv_acc_pkg::st_done;
					end
				end
			end
			conv_acc_pkg::st_load_window: begin
				if (rd_done) begin
					next_state = conv_acc_pkg::st_write;
				end
			end
			conv_acc_pkg::st_write: begin
				if (win_final) begin
					next_state = conv_acc_pkg::st_done;
				end else begin
					next_state = conv_acc_pkg::st_load_window;
				end
			end
			default: begin
				next_state = conv_acc_pkg::st_idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			load_cnt <= 2'd0;
		end else if (state == conv_acc_pkg::st_load_param) begin
			load_cnt <= load_cnt + 2'd1;
		end else begin
			load_cnt <= 2'd0;
		end
	end

	// read data lags the address by one cycle
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rows     <= 8'd0;
			channels <= 8'd0;
			k_is4    <= 1'b0;
		end else if (state == conv_acc_pkg::st_load_param) begin
			case (load_cnt)
				2'd1:    rows <= param_rdata;
				2'd2:    channels <= param_rdata;
				2'd3:    k_is4 <= (param_rdata == 8'd4);
				default: ;
			endcase
		end
	end

	// element offsets inside the window
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			col_off <= 2'd0;
			row_off <= 2'd0;
			rd_done <= 1'b0;
		end else if (reading) begin
			if (elem_last) begin
				col_off <= 2'd0;
				row_off <= 2'd0;
				rd_done <= 1'b1;
			end else if (col_off == k_last) begin
				col_off <= 2'd0;
				row_off <= row_off + 2'd1;
			end else begin
				col_off <= col_off + 2'd1;
			end
		end else if (state != conv_acc_pkg::st_load_window) begin
			col_off <= 2'd0;
			row_off <= 2'd0;
			rd_done <= 1'b0;
		end
	end

	// window position, stepped once per written result
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			win_col  <= 8'd0;
			win_row  <= 8'd0;
			chan     <= 8'd0;
			out_addr <= '0;
		end else if (state == conv_acc_pkg::st_load_param) begin
			win_col  <= 8'd0;
			win_row  <= 8'd0;
			chan     <= 8'd0;
			out_addr <= '0;
		end else if (state == conv_acc_pkg::st_write) begin
			out_addr <= out_addr + 1'b1;
			if (win_col == win_last) begin
				win_col <= 8'd0;
				if (win_row == win_last) begin
					win_row <= 8'd0;
					chan    <= chan + 8'd1;
				end else begin
					win_row <= win_row + 8'd1;
				end
			end else begin
				win_col <= win_col + 8'd1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rd_valid <= 1'b0;
			rd_first <= 1'b0;
		end else begin
			rd_valid <= reading;
			rd_first <= reading && (col_off == 2'd0) && (row_off == 2'd0);
		end
	end

	assign pixel     = input_rdata;
	assign fold_base = rd_first ? conv_acc_pkg::pixel_min : run_max;

	// signed compare, so 0x7f beats any negative pixel
	always_ff @(posedge clk) begin
		if (rd_valid) begin
			run_max <= (pixel > fold_base) ? pixel : fold_base;
		end
	end

	assign busy   = (state != conv_acc_pkg::st_idle);
	assign finish = (state == conv_acc_pkg::st_done);

	always_comb begin
		param_req        = '0;
		param_req.cs     = (state == conv_acc_pkg::st_load_param) && (load_cnt != 2'd3);
		param_req.addr   = 16'(param_addr);
		input_req        = '0;
		input_req.cs     = reading;
		input_req.addr   = 16'(rd_addr);
		output_req       = '0;
		output_req.cs    = (state == conv_acc_pkg::st_write);
		output_req.we    = (state == conv_acc_pkg::st_write);
		output_req.addr  = 16'(out_addr);
		output_req.wdata = run_max;
	end

	// a result goes out only right after its last fold
	a_write_after_fold: assert property (
		@(posedge clk) disable iff (!rst)
		output_req.we |-> $past(rd_valid) && !rd_valid
	) else begin
		$error("output write not right after the last fold of a window");
	end

	a_finish_quiet: assert property (
		@(posedge clk) disable iff (!rst)
		finish |-> !(param_req.cs || input_req.cs || output_req.cs) ##1 !busy
	) else begin
		$error("bank access during finish or engine still busy after it");
	end

endmodule

/* buffer_bank.sv */
module buffer_bank #(
	parameter int ADDR_W = 12
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   busy,
	input  logic                   host_hit,
	input  conv_acc_pkg::ram_req_t host_req,
	input  conv_acc_pkg::ram_req_t eng_req,
	output logic [7:0]             rdata
);

	conv_acc_pkg::ram_req_t ram_req;

	// engine owns the bank for the whole run
	always_comb begin
		if (busy) begin
			ram_req = eng_req;
		end else if (host_hit) begin
			ram_req = host_req;
		end else begin
			ram_req = '0;
		end
	end

	sp_ram #(
		.ADDR_W(ADDR_W),
		.DATA_W(8)
	) u_ram (
		.clk  (clk),
		.req  (ram_req),
		.rdata(rdata)
	);

	// host has to wait until busy drops
	a_host_idle: assert property (
		@(posedge clk) disable iff (!rst)
		!(busy && host_hit && host_req.cs)
	) else begin
		$error("host access to bank while engine is busy");
	end

	a_eng_busy: assert property (
		@(posedge clk) disable iff (!rst)
		eng_req.cs |-> busy
	) else begin
		$error("engine access to bank while not busy");
	end

endmodule

/* sp_ram.sv */
module sp_ram #(
	parameter int ADDR_W = 12,
	parameter int DATA_W = 8
) (
	input  logic                   clk,
	input  conv_acc_pkg::ram_req_t req,
	output logic [DATA_W-1:0]      rdata
);

	localparam int depth = 1 << ADDR_W;

	logic [DATA_W-1:0] mem [depth];
	logic [ADDR_W-1:0] addr;

	// bank depth sets how much of the shared address is decoded
	assign addr = req.addr[ADDR_W-1:0];

	// one port: write or registered read, never both
	always_ff @(posedge clk) begin
		if (req.cs) begin
			if (req.we) begin
				mem[addr] <= DATA_W'(req.wdata);
			end else begin
				rdata <= mem[addr];
			end
		end
	end

endmodule

/* conv_acc_pkg.sv */
package conv_acc_pkg;

	localparam int req_addr_w = 16;
	localparam int req_data_w = 8;

	// one access to a buffer, used by host and engine alike
	typedef struct packed {
		logic                  cs;
		logic                  we;
		logic [req_addr_w-1:0] addr;
		logic [req_data_w-1:0] wdata;
	} ram_req_t;

	// bank the host port addresses
	typedef enum logic [1:0] {
		bank_param  = 2'd0,
		bank_input  = 2'd1,
		bank_output = 2'd2
	} bank_sel_t;

	typedef enum logic [2:0] {
		st_idle        = 3'd0,
		// three reads plus one latency cycle
		st_load_param  = 3'd1,
		// k*k reads plus the last fold
		st_load_window = 3'd2,
		st_write       = 3'd3,
		// one cycle, finish is high here
		st_done        = 3'd4
	} pool_state_t;

	// parameter buffer layout
	localparam logic [req_addr_w-1:0] param_addr_rows     = 16'd0;
	localparam logic [req_addr_w-1:0] param_addr_channels = 16'd1;
	localparam logic [req_addr_w-1:0] param_addr_kernel   = 16'd2;

	// most negative pixel, seed of the running maximum
	localparam logic signed [7:0] pixel_min = 8'sh80;

endpackage
